// File: vlog.f
design/ahb_pkg.sv
design/ahb_addr_decoder.sv
design/ahb_sram_ctrl.sv
design/ahb_wait_timer.sv
design/ahb_sram_store.sv
design/ahb_default_slave.sv
design/ahb_resp_mux.sv
design/ahb_subsys_top.sv
dv/tb_clk_gen.sv
dv/ahb_subsys_asserts.sv
dv/ahb_subsys_tb.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the AHB subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing --assert --top-module ahb_subsys_tb \
  -Mdir "$BUILD_DIR" -f vlog.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/Vahb_subsys_tb" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -q "Result: FAILED" "$LOG_FILE"; then
  exit 1
fi
if ! grep -q "Result: PASSED" "$LOG_FILE"; then
  echo "Simulation ended without a result line"
  exit 1
fi
exit 0

// File: dv/ahb_subsys_tb.sv
// AHB subsystem directed testbench
`timescale 1ns/100ps
`default_nettype none

module ahb_subsys_tb;

  import ahb_pkg::*;

  // Cycle limits for each wait loop
  localparam int READY_TIMEOUT = 20;
  localparam int RESET_TIMEOUT = 10;
  localparam logic [31:0] LFSR_SEED = 32'h6fb7_6f04;
  // Galois feedback mask
  localparam logic [31:0] LFSR_TAPS = 32'hD000_0001;
  localparam int BURST_LEN = 12;

  logic                      hclk;
  logic                      rst_n;
  logic [AHB_ADDR_WIDTH-1:0] haddr;
  htrans_type                htrans;
  logic                      hwrite;
  logic [2:0]                hsize;
  logic [AHB_DATA_WIDTH-1:0] hwdata;
  logic [AHB_DATA_WIDTH-1:0] hrdata;
  logic                      hready;
  logic                      hresp;

  // Bookkeeping
  string test_name;
  int    err_count;
  int    check_total;
  int    test_total;
  int    test_failed;
  int    test_err_start;
  int    assert_fails;
  logic [31:0] lfsr_state;

  // Burst stimulus and reference memory
  logic [AHB_ADDR_WIDTH-1:0] burst_addr [BURST_LEN];
  logic [AHB_DATA_WIDTH-1:0] burst_data [BURST_LEN];
  logic [AHB_DATA_WIDTH-1:0] model_mem [logic [AHB_ADDR_WIDTH-1:0]];

  tb_clk_gen i_clk_gen (.hclk(hclk), .rst_n(rst_n));

  ahb_subsys_top i_dut (
    .hclk(hclk), .rst_n(rst_n), .haddr(haddr), .htrans(htrans), .hwrite(hwrite),
    .hsize(hsize), .hwdata(hwdata), .hrdata(hrdata), .hready(hready), .hresp(hresp)
  );

  // ==========================================================================
  // Helpers
  // ==========================================================================
  // One output bit per LFSR step
  function automatic logic [31:0] lfsr_take(input int nbits);
    logic [31:0] value;
    logic        out_bit;
    value = '0;
    for (int i = 0; i < nbits; i++) begin
      out_bit    = lfsr_state[0];
      lfsr_state = lfsr_state >> 1;
      if (out_bit) begin
        lfsr_state = lfsr_state ^ LFSR_TAPS;
      end
      value = {value[30:0], out_bit};
    end
    return value;
  endfunction

  // Lanes offset .. offset+nbytes-1 come from the new word
  function automatic logic [31:0] merge_lanes(input logic [31:0] old_word,
      input logic [31:0] new_word, input int offset, input int nbytes);
    logic [31:0] merged;
    merged = old_word;
    for (int b = 0; b < 4; b++) begin
      if (b >= offset && b < offset + nbytes) begin
        merged[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return merged;
  endfunction

  task automatic check_data(input string what, input logic [AHB_DATA_WIDTH-1:0] expected,
      input logic [AHB_DATA_WIDTH-1:0] actual);
    check_total++;
    if (actual !== expected) begin
      err_count++;
      $display("FAILED %s: %s expected %h actual %h", test_name, what, expected, actual);
    end
  endtask

  task automatic check_resp(input string what, input logic expected, input logic actual);
    check_total++;
    if (actual !== expected) begin
      err_count++;
      $display("FAILED %s: %s expected %b actual %b", test_name, what, expected, actual);
    end
  endtask

  task automatic check_count(input string what, input int expected, input int actual);
    check_total++;
    if (actual != expected) begin
      err_count++;
      $display("FAILED %s: %s expected %0d actual %0d", test_name, what, expected, actual);
    end
  endtask

  task automatic start_test(input string name);
    test_name      = name;
    test_err_start = err_count;
    test_total++;
  endtask

  task automatic end_test();
    if (err_count == test_err_start) begin
      $display("test %s: ok", test_name);
    end else begin
      test_failed++;
      $display("test %s: %0d errors", test_name, err_count - test_err_start);
    end
  endtask

  task automatic wait_reset();
    int cycles;
    cycles = 0;
    while (rst_n !== 1'b1) begin
      @(negedge hclk);
      cycles++;
      if (cycles > RESET_TIMEOUT) begin
        $display("reset never released");
        $display("Result: FAILED");
        $finish;
      end
    end
    @(negedge hclk);
  endtask

  // Counts falling edges seen with hready low
  task automatic wait_ready(output int waits);
    waits = 0;
    while (hready !== 1'b1) begin
      @(negedge hclk);
      waits++;
      if (waits > READY_TIMEOUT) begin
        $display("hready stuck low in test %s", test_name);
        $display("Result: FAILED");
        $finish;
      end
    end
  endtask

  task automatic drive_addr(input logic [31:0] addr, input htrans_type trans,
      input logic write, input logic [2:0] size);
    haddr  = addr;
    htrans = trans;
    hwrite = write;
    hsize  = size;
  endtask

  // Address phase then a data phase with IDLE behind it
  task automatic single_xfer(input logic [31:0] addr, input htrans_type trans,
      input logic write, input logic [2:0] size, input logic [31:0] wdata,
      output logic [31:0] rdata, output logic resp, output int waits);
    int addr_waits;
    drive_addr(addr, trans, write, size);
    wait_ready(addr_waits);
    @(negedge hclk);
    drive_addr(addr, IDLE, 1'b0, size);
    hwdata = wdata;
    wait_ready(waits);
    rdata = hrdata;
    resp  = hresp;
    @(negedge hclk);
  endtask

  // Closes the pending data phase while the next address waits
  task automatic burst_step(input logic write, input int pend);
    int waits;
    if (pend >= 0 && write) begin
      hwdata = burst_data[pend];
    end
    wait_ready(waits);
    if (pend >= 0) begin
      check_resp("burst hresp", HRESP_OKAY, hresp);
      if (!write) begin
        check_data($sformatf("burst read %0d", pend), model_mem[burst_addr[pend]], hrdata);
      end
    end
    @(negedge hclk);
  endtask

  task automatic burst_pass(input logic write);
    int pend;
    pend = -1;
    for (int i = 0; i <= BURST_LEN; i++) begin
      // BUSY slot every third beat
      if (i > 0 && i < BURST_LEN && (i % 3) == 0) begin
        drive_addr(haddr, BUSY, write, HSIZE_WORD);
        burst_step(write, pend);
        pend = -1;
      end
      if (i < BURST_LEN) begin
        drive_addr(burst_addr[i], (i == 0) ? NONSEQ : SEQ, write, HSIZE_WORD);
      end else begin
        drive_addr(haddr, IDLE, 1'b0, HSIZE_WORD);
      end
      burst_step(write, pend);
      pend = (i < BURST_LEN) ? i : -1;
    end
  endtask

  // ==========================================================================
  // Tests
  // ==========================================================================
  task automatic test_reset_idle();
    start_test("reset_idle");
    check_count("hready", 1, int'(hready));
    check_resp("hresp", HRESP_OKAY, hresp);
    @(negedge hclk);
    check_count("hready idle", 1, int'(hready));
    end_test();
  endtask

  task automatic test_write_read_pipelined();
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [31:0] rdata;
    logic        wresp;
    logic        rresp;
    int          waits;
    start_test("write_read_pipelined");
    addr  = lfsr_take(13) << 2;
    wdata = lfsr_take(32);
    drive_addr(addr, NONSEQ, 1'b1, HSIZE_WORD);
    wait_ready(waits);
    @(negedge hclk);
    // Read address phase overlaps the write data phase
    hwdata = wdata;
    drive_addr(addr, NONSEQ, 1'b0, HSIZE_WORD);
    wait_ready(waits);
    wresp = hresp;
    @(negedge hclk);
    drive_addr(addr, IDLE, 1'b0, HSIZE_WORD);
    wait_ready(waits);
    rdata = hrdata;
    rresp = hresp;
    @(negedge hclk);
    check_resp("write hresp", HRESP_OKAY, wresp);
    check_resp("read hresp", HRESP_OKAY, rresp);
    check_data("read data", wdata, rdata);
    end_test();
  endtask

  task automatic test_byte_lanes();
    int          lane_off [4] = '{1, 2, 0, 3};
    logic [2:0]  lane_size [4] = '{HSIZE_BYTE, HSIZE_HALF, HSIZE_BYTE, HSIZE_BYTE};
    logic [31:0] base;
    logic [31:0] expected;
    logic [31:0] wdata;
    logic [31:0] rdata;
    logic        resp;
    int          waits;
    start_test("byte_lanes");
    base     = 32'h0000_1000 | (lfsr_take(10) << 2);
    expected = lfsr_take(32);
    single_xfer(base, NONSEQ, 1'b1, HSIZE_WORD, expected, rdata, resp, waits);
    for (int k = 0; k < 4; k++) begin
      // Unselected lanes carry noise
      wdata = lfsr_take(32);
      single_xfer(base + lane_off[k], NONSEQ, 1'b1, lane_size[k], wdata, rdata, resp, waits);
      check_resp("narrow write hresp", HRESP_OKAY, resp);
      expected = merge_lanes(expected, wdata, lane_off[k], 1 << lane_size[k]);
    end
    single_xfer(base, NONSEQ, 1'b0, HSIZE_WORD, '0, rdata, resp, waits);
    check_resp("read hresp", HRESP_OKAY, resp);
    check_data("merged word", expected, rdata);
    end_test();
  endtask

  task automatic test_unmapped();
    logic [31:0] rdata;
    logic        resp;
    int          waits;
    start_test("unmapped");
    drive_addr(32'h0000_8000, NONSEQ, 1'b0, HSIZE_WORD);
    wait_ready(waits);
    @(negedge hclk);
    drive_addr(32'h0000_8000, IDLE, 1'b0, HSIZE_WORD);
    check_count("error cycle 1 hready", 0, int'(hready));
    check_resp("error cycle 1 hresp", HRESP_ERROR, hresp);
    @(negedge hclk);
    check_count("error cycle 2 hready", 1, int'(hready));
    check_resp("error cycle 2 hresp", HRESP_ERROR, hresp);
    @(negedge hclk);
    // Top of the address space
    single_xfer(32'hFFFF_FFFC, SEQ, 1'b1, HSIZE_WORD, lfsr_take(32), rdata, resp, waits);
    check_count("seq error waits", 1, waits);
    check_resp("seq error hresp", HRESP_ERROR, resp);
    single_xfer(32'h0000_8000, IDLE, 1'b0, HSIZE_WORD, '0, rdata, resp, waits);
    check_count("idle waits", 0, waits);
    check_resp("idle hresp", HRESP_OKAY, resp);
    single_xfer(32'h0000_8000, BUSY, 1'b0, HSIZE_WORD, '0, rdata, resp, waits);
    check_count("busy waits", 0, waits);
    check_resp("busy hresp", HRESP_OKAY, resp);
    end_test();
  endtask

  task automatic test_wait_states();
    logic [31:0] addr;
    logic [31:0] rdata;
    logic        resp;
    int          waits;
    start_test("wait_states");
    addr = 32'h0000_2000 | (lfsr_take(8) << 2);
    single_xfer(addr, NONSEQ, 1'b1, HSIZE_WORD, lfsr_take(32), rdata, resp, waits);
    check_count("word write waits", SRAM_WAIT_STATES, waits);
    single_xfer(addr, NONSEQ, 1'b0, HSIZE_WORD, '0, rdata, resp, waits);
    check_count("word read waits", SRAM_WAIT_STATES, waits);
    single_xfer(addr + 32'd1, NONSEQ, 1'b1, HSIZE_BYTE, lfsr_take(32), rdata, resp, waits);
    check_count("byte write waits", SRAM_WAIT_STATES, waits);
    single_xfer(addr + 32'd2, NONSEQ, 1'b0, HSIZE_HALF, '0, rdata, resp, waits);
    check_count("half read waits", SRAM_WAIT_STATES, waits);
    end_test();
  endtask

  task automatic test_burst();
    start_test("burst");
    for (int i = 0; i < BURST_LEN; i++) begin
      burst_addr[i] = lfsr_take(13) << 2;
      burst_data[i] = lfsr_take(32);
    end
    // Later beats win on a repeated address
    for (int i = 0; i < BURST_LEN; i++) begin
      model_mem[burst_addr[i]] = burst_data[i];
    end
    burst_pass(1'b1);
    burst_pass(1'b0);
    end_test();
  endtask

  // ==========================================================================
  // Sequence
  // ==========================================================================
  initial begin
    haddr       = '0;
    htrans      = IDLE;
    hwrite      = 1'b0;
    hsize       = HSIZE_WORD;
    hwdata      = '0;
    err_count   = 0;
    check_total = 0;
    test_total  = 0;
    test_failed = 0;
    lfsr_state  = LFSR_SEED;
    wait_reset();
    test_reset_idle();
    test_write_read_pipelined();
    test_byte_lanes();
    test_unmapped();
    test_wait_states();
    test_burst();
    // Failures of the bound protocol checks
    assert_fails = i_dut.i_asserts.fail_count;
    $display("tests %0d, failed %0d, checks %0d, errors %0d, assertion failures %0d",
             test_total, test_failed, check_total, err_count, assert_fails);
    if (err_count == 0 && assert_fails == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: dv/ahb_subsys_asserts.sv
// AHB subsystem protocol checks
`timescale 1ns/100ps
`default_nettype none

module ahb_subsys_asserts (
  input wire                          hclk,
  input wire                          rst_n,
  input wire [ahb_pkg::SLAVE_NUM-1:0] hreq,
  input wire                          default_slv_sel,
  input wire                          hready,
  input wire                          hresp
);

  import ahb_pkg::*;

  // A slave owns the current data phase
  logic data_pending;
  // Low cycles seen so far in this stretch
  int   low_cycles;
  // Failed assertions so far
  int   fail_count = 0;

  always_ff @(posedge hclk or negedge rst_n) begin
    if (!rst_n) begin
      data_pending <= 1'b0;
      low_cycles   <= 0;
    end else begin
      // Address phase moves into the data phase only on a ready edge
      if (hready) begin
        data_pending <= (|hreq) || default_slv_sel;
      end
      low_cycles <= hready ? 0 : low_cycles + 1;
    end
  end

  // ==========================================================================
  // Response rules
  // ==========================================================================
  a_idle_okay: assert property (@(posedge hclk) disable iff (!rst_n)
    !data_pending |-> (hresp == HRESP_OKAY))
    else begin
      fail_count = fail_count + 1;
      $error("hresp not OKAY with no data phase pending");
    end

  // First ERROR cycle is followed by the ready one
  a_error_second: assert property (@(posedge hclk) disable iff (!rst_n)
    (hresp == HRESP_ERROR && !hready) |=> (hresp == HRESP_ERROR && hready))
    else begin
      fail_count = fail_count + 1;
      $error("ERROR response not closed by a ready ERROR cycle");
    end

  a_error_first: assert property (@(posedge hclk) disable iff (!rst_n)
    (hresp == HRESP_ERROR && hready) |-> $past(hresp == HRESP_ERROR && !hready))
    else begin
      fail_count = fail_count + 1;
      $error("ready ERROR cycle without a preceding wait cycle");
    end

  // Bounded back-pressure
  a_wait_limit: assert property (@(posedge hclk) disable iff (!rst_n)
    !hready |-> (low_cycles <= SRAM_WAIT_STATES))
    else begin
      fail_count = fail_count + 1;
      $error("hready held low too long");
    end

endmodule

bind ahb_subsys_top ahb_subsys_asserts i_asserts (
  .hclk(hclk), .rst_n(rst_n), .hreq(hreq), .default_slv_sel(default_slv_sel),
  .hready(hready), .hresp(hresp)
);

`default_nettype wire

// File: dv/tb_clk_gen.sv
// Testbench clock and reset
`timescale 1ns/100ps
`default_nettype none

module tb_clk_gen (
  output logic hclk,
  output logic rst_n
);

  // 40 ns clock, reset held for two cycles
  localparam int PERIOD_NS    = 40;
  localparam int RESET_CYCLES = 2;

  initial begin
    hclk = 1'b0;
    forever #(PERIOD_NS / 2) hclk = ~hclk;
  end

  // Release lands on a falling edge
  initial begin
    rst_n = 1'b0;
    #(PERIOD_NS * RESET_CYCLES) rst_n = 1'b1;
  end

endmodule

`default_nettype wire

// File: design/ahb_subsys_top.sv
// AHB-Lite SRAM subsystem top
`timescale 1ns/100ps
`default_nettype none

module ahb_subsys_top (
  input  wire                                hclk,
  input  wire                                rst_n,
  input  wire [ahb_pkg::AHB_ADDR_WIDTH-1:0]  haddr,
  input  wire ahb_pkg::htrans_type           htrans,
  input  wire                                hwrite,
  input  wire [2:0]                          hsize,
  input  wire [ahb_pkg::AHB_DATA_WIDTH-1:0]  hwdata,
  output logic [ahb_pkg::AHB_DATA_WIDTH-1:0] hrdata,
  output logic                               hready,
  output logic                               hresp
);

  import ahb_pkg::*;

  // Decoder outputs
  logic [SLAVE_NUM-1:0]       hreq;
  logic                       default_slv_sel;
  // Timer handshake
  logic                       timer_start;
  logic                       timer_done;
  // Store port
  logic [SRAM_ADDR_WIDTH-1:0] mem_addr;
  logic [AHB_STRB_WIDTH-1:0]  mem_be;
  logic [AHB_DATA_WIDTH-1:0]  mem_wdata;
  logic                       mem_we;
  logic                       mem_re;
  logic [AHB_DATA_WIDTH-1:0]  mem_rdata;
  // Slave responses
  logic                       sram_ready;
  logic                       sram_resp;
  logic                       dflt_ready;
  logic                       dflt_resp;

  // ==========================================================================
  // Address phase
  // ==========================================================================
  ahb_addr_decoder i_decoder (
    .haddr(haddr), .htrans(htrans), .hreq(hreq), .default_slv_sel(default_slv_sel)
  );

  // ==========================================================================
  // Slaves, bus hready fed back as hready_in
  // ==========================================================================
  ahb_sram_ctrl i_sram_ctrl (
    .hclk(hclk), .rst_n(rst_n), .hsel(hreq[0]), .haddr(haddr), .htrans(htrans),
    .hwrite(hwrite), .hsize(hsize), .hwdata(hwdata), .hready_in(hready),
    .timer_done(timer_done), .timer_start(timer_start), .mem_addr(mem_addr),
    .mem_be(mem_be), .mem_wdata(mem_wdata), .mem_we(mem_we), .mem_re(mem_re),
    .sram_ready(sram_ready), .sram_resp(sram_resp)
  );

  ahb_wait_timer i_wait_timer (
    .hclk(hclk), .rst_n(rst_n), .timer_start(timer_start), .timer_done(timer_done)
  );

  ahb_sram_store i_sram_store (
    .hclk(hclk), .mem_addr(mem_addr), .mem_be(mem_be), .mem_wdata(mem_wdata),
    .mem_we(mem_we), .mem_re(mem_re), .mem_rdata(mem_rdata)
  );

  ahb_default_slave i_default_slave (
    .hclk(hclk), .rst_n(rst_n), .hsel(default_slv_sel), .htrans(htrans),
    .hready_in(hready), .dflt_ready(dflt_ready), .dflt_resp(dflt_resp)
  );

  // Data phase return to the master
  ahb_resp_mux i_resp_mux (
    .hclk(hclk), .rst_n(rst_n), .hreq(hreq), .default_slv_sel(default_slv_sel),
    .hready_in(hready), .sram_rdata(mem_rdata), .sram_ready(sram_ready),
    .sram_resp(sram_resp), .dflt_ready(dflt_ready), .dflt_resp(dflt_resp),
    .hrdata(hrdata), .hready(hready), .hresp(hresp)
  );

endmodule

`default_nettype wire

// File: design/ahb_resp_mux.sv
// AHB slave response mux
`timescale 1ns/100ps
`default_nettype none

module ahb_resp_mux (
  input  wire                                hclk,
  input  wire                                rst_n,
  input  wire [ahb_pkg::SLAVE_NUM-1:0]       hreq,
  input  wire                                default_slv_sel,
  input  wire                                hready_in,
  input  wire [ahb_pkg::AHB_DATA_WIDTH-1:0]  sram_rdata,
  input  wire                                sram_ready,
  input  wire                                sram_resp,
  input  wire                                dflt_ready,
  input  wire                                dflt_resp,
  output logic [ahb_pkg::AHB_DATA_WIDTH-1:0] hrdata,
  output logic                               hready,
  output logic                               hresp
);

  import ahb_pkg::*;

  // Owner of the current data phase
  logic [SLAVE_NUM-1:0] slv_sel_q;
  logic                 dflt_sel_q;

  // Advances with the address phase
  always_ff @(posedge hclk or negedge rst_n) begin
    if (!rst_n) begin
      slv_sel_q  <= '0;
      dflt_sel_q <= 1'b0;
    end else if (hready_in) begin
      slv_sel_q  <= hreq;
      dflt_sel_q <= default_slv_sel;
    end
  end

  // ==========================================================================
  // Return path
  // ==========================================================================
  always_comb begin
    // No owner, zero-wait OKAY
    hrdata = '0;
    hready = 1'b1;
    hresp  = HRESP_OKAY;
    if (slv_sel_q[0]) begin
      hrdata = sram_rdata;
      hready = sram_ready;
      hresp  = sram_resp;
    end else if (dflt_sel_q) begin
      hready = dflt_ready;
      hresp  = dflt_resp;
    end
  end

endmodule

`default_nettype wire

// File: design/ahb_default_slave.sv
// AHB default slave
`timescale 1ns/100ps
`default_nettype none

module ahb_default_slave (
  input  wire                       hclk,
  input  wire                       rst_n,
  input  wire                       hsel,
  input  wire ahb_pkg::htrans_type  htrans,
  input  wire                       hready_in,
  output logic                      dflt_ready,
  output logic                      dflt_resp
);

  import ahb_pkg::*;

  // FIRST holds hready low, SECOND releases it
  typedef enum logic [1:0] {DS_IDLE, DS_FIRST, DS_SECOND} state_t;

  state_t state_q;
  state_t state_d;
  logic   accept;

  // Unmapped active transfer sampled on a ready edge
  assign accept = hsel && hready_in && htrans_active(htrans);

  // ==========================================================================
  // ERROR sequencer
  // ==========================================================================
  always_comb begin
    state_d = state_q;
    unique case (state_q)
      DS_IDLE:   if (accept) state_d = DS_FIRST;
      DS_FIRST:  state_d = DS_SECOND;
      // Back-to-back bad transfers restart at once
      DS_SECOND: state_d = accept ? DS_FIRST : DS_IDLE;
      default:   state_d = DS_IDLE;
    endcase
  end

  always_ff @(posedge hclk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= DS_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // ERROR in both cycles
  assign dflt_ready = (state_q != DS_FIRST);
  assign dflt_resp  = (state_q == DS_IDLE) ? HRESP_OKAY : HRESP_ERROR;

endmodule

`default_nettype wire

// File: design/ahb_sram_store.sv
// SRAM word store
`timescale 1ns/100ps
`default_nettype none

module ahb_sram_store (
  input  wire                                 hclk,
  input  wire [ahb_pkg::SRAM_ADDR_WIDTH-1:0]  mem_addr,
  input  wire [3:0]                           mem_be,
  input  wire [ahb_pkg::AHB_DATA_WIDTH-1:0]   mem_wdata,
  input  wire                                 mem_we,
  input  wire                                 mem_re,
  output logic [ahb_pkg::AHB_DATA_WIDTH-1:0]  mem_rdata
);

  import ahb_pkg::*;

  // Word array, contents undefined at power-up
  logic [AHB_DATA_WIDTH-1:0] mem [SRAM_DEPTH];

  // ==========================================================================
  // Write port
  // ==========================================================================
  always_ff @(posedge hclk) begin
    if (mem_we) begin
      // One enable per byte lane
      for (int i = 0; i < AHB_STRB_WIDTH; i++) begin
        if (mem_be[i]) begin
          mem[mem_addr][8*i +: 8] <= mem_wdata[8*i +: 8];
        end
      end
    end
  end

  // ==========================================================================
  // Read port
  // ==========================================================================
  // Registered, holds last word between reads
  always_ff @(posedge hclk) begin
    if (mem_re) begin
      mem_rdata <= mem[mem_addr];
    end
  end

endmodule

`default_nettype wire

// File: design/ahb_wait_timer.sv
// SRAM wait-state timer
`timescale 1ns/100ps
`default_nettype none

module ahb_wait_timer (
  input  wire  hclk,
  input  wire  rst_n,
  input  wire  timer_start,
  output logic timer_done
);

  import ahb_pkg::*;

  // Wait cycles left, zero when idle
  logic [WAIT_CNT_WIDTH-1:0] count_q;

  // ==========================================================================
  // Down-counter
  // ==========================================================================
  always_ff @(posedge hclk or negedge rst_n) begin
    if (!rst_n) begin
      count_q <= '0;
    end else if (timer_start) begin
      // Reload wins over a running count
      count_q <= WAIT_CNT_WIDTH'(SRAM_WAIT_STATES);
    end else if (count_q != '0) begin
      count_q <= count_q - 1'b1;
    end
  end

  // Last wait cycle
  // count steps to zero at the next edge, so one pulse per start
  assign timer_done = (count_q == WAIT_CNT_WIDTH'(1));

endmodule

`default_nettype wire

// File: design/ahb_sram_ctrl.sv
// SRAM slave data-phase controller
`timescale 1ns/100ps
`default_nettype none

module ahb_sram_ctrl (
  input  wire                                 hclk,
  input  wire                                 rst_n,
  input  wire                                 hsel,
  input  wire [ahb_pkg::AHB_ADDR_WIDTH-1:0]   haddr,
  input  wire ahb_pkg::htrans_type            htrans,
  input  wire                                 hwrite,
  input  wire [2:0]                           hsize,
  input  wire [ahb_pkg::AHB_DATA_WIDTH-1:0]   hwdata,
  input  wire                                 hready_in,
  input  wire                                 timer_done,
  output logic                                timer_start,
  output logic [ahb_pkg::SRAM_ADDR_WIDTH-1:0] mem_addr,
  output logic [3:0]                          mem_be,
  output logic [ahb_pkg::AHB_DATA_WIDTH-1:0]  mem_wdata,
  output logic                                mem_we,
  output logic                                mem_re,
  output logic                                sram_ready,
  output logic                                sram_resp
);

  import ahb_pkg::*;

  // WAIT holds hready low, LAST ends the data phase
  typedef enum logic [1:0] {ST_IDLE, ST_WAIT, ST_LAST} state_t;

  state_t                     state_q;
  state_t                     state_d;
  logic                       accept;
  logic                       write_q;
  logic [SRAM_ADDR_WIDTH-1:0] addr_q;
  logic [AHB_STRB_WIDTH-1:0]  be_q;
  logic [AHB_STRB_WIDTH-1:0]  be_d;

  // Address phase sampled only while the bus is ready
  assign accept      = hsel && hready_in && htrans_active(htrans);
  assign timer_start = accept;

  // Byte lanes from size and low address bits
  always_comb begin
    case (hsize)
      HSIZE_BYTE: be_d = 4'b0001 << haddr[1:0];
      HSIZE_HALF: be_d = haddr[1] ? 4'b1100 : 4'b0011;
      HSIZE_WORD: be_d = 4'b1111;
      // Wider sizes do not fit the bus, treated as word
      default:    be_d = 4'b1111;
    endcase
  end

  // ==========================================================================
  // Data-phase FSM
  // ==========================================================================
  always_comb begin
    state_d = state_q;
    unique case (state_q)
      ST_IDLE: if (accept) state_d = ST_WAIT;
      ST_WAIT: if (timer_done) state_d = ST_LAST;
      // Pipelined transfer may start right away
      ST_LAST: state_d = accept ? ST_WAIT : ST_IDLE;
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge hclk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= ST_IDLE;
      write_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (accept) begin
        write_q <= hwrite;
      end
    end
  end

  // Captured address phase
  always_ff @(posedge hclk) begin
    if (accept) begin
      addr_q <= haddr[SRAM_ADDR_WIDTH+1:2];
      be_q   <= be_d;
    end
  end

  // Memory side
  assign mem_addr  = addr_q;
  assign mem_be    = be_q;
  assign mem_wdata = hwdata;
  // Write at the edge that closes the data phase
  assign mem_we    = (state_q == ST_LAST) && write_q;
  // Read one cycle early so data lands in LAST
  assign mem_re    = (state_q == ST_WAIT) && timer_done && !write_q;

  // Bus side
  assign sram_ready = (state_q != ST_WAIT);
  assign sram_resp  = HRESP_OKAY;

endmodule

`default_nettype wire

// File: design/ahb_addr_decoder.sv
// AHB address-phase decoder
`timescale 1ns/100ps
`default_nettype none

module ahb_addr_decoder (
  input  wire [ahb_pkg::AHB_ADDR_WIDTH-1:0] haddr,
  input  wire ahb_pkg::htrans_type          htrans,
  output logic [ahb_pkg::SLAVE_NUM-1:0]     hreq,
  output logic                              default_slv_sel
);

  import ahb_pkg::*;

  // Raw region hits, before the transfer type is looked at
  logic [SLAVE_NUM-1:0] slave_hit;
  // Transfer needs a slave at all
  logic                 trans_active;

  // ==========================================================================
  // Region compare
  // ==========================================================================
  for (genvar i = 0; i < SLAVE_NUM; i++) begin : g_region
    always_comb begin
      slave_hit[i] = 1'b0;
      // Both bounds inclusive
      if ((haddr >= SLAVE_LOW_ADDR[i]) && (haddr <= SLAVE_HIGH_ADDR[i])) begin
        slave_hit[i] = 1'b1;
      end
    end
  end

  // BUSY is treated like IDLE here
  assign trans_active = htrans_active(htrans);

  // ==========================================================================
  // Select outputs
  // ==========================================================================
  // Only active transfers request a slave
  assign hreq = trans_active ? slave_hit : '0;

  // Active transfer outside every region goes to the default slave
  assign default_slv_sel = trans_active && ~|slave_hit;

endmodule

`default_nettype wire

// File: design/ahb_pkg.sv
// AHB-Lite subsystem definitions
`default_nettype none

package ahb_pkg;

  // ==========================================================================
  // Bus geometry
  // ==========================================================================
  localparam int AHB_ADDR_WIDTH = 32;
  localparam int AHB_DATA_WIDTH = 32;
  // One strobe per byte lane
  localparam int AHB_STRB_WIDTH = AHB_DATA_WIDTH / 8;

  // Transfer type on htrans
  typedef enum logic [1:0] {
    IDLE   = 2'b00,
    BUSY   = 2'b01,
    NONSEQ = 2'b10,
    SEQ    = 2'b11
  } htrans_type;

  // Supported hsize codes
  localparam logic [2:0] HSIZE_BYTE = 3'b000;
  localparam logic [2:0] HSIZE_HALF = 3'b001;
  localparam logic [2:0] HSIZE_WORD = 3'b010;

  // Response codes on hresp
  localparam logic HRESP_OKAY  = 1'b0;
  localparam logic HRESP_ERROR = 1'b1;

  // ==========================================================================
  // Address map, inclusive bounds per slave
  // ==========================================================================
  localparam int SLAVE_NUM = 1;
  localparam logic [SLAVE_NUM-1:0][AHB_ADDR_WIDTH-1:0] SLAVE_LOW_ADDR  = {32'h0000_0000};
  localparam logic [SLAVE_NUM-1:0][AHB_ADDR_WIDTH-1:0] SLAVE_HIGH_ADDR = {32'h0000_7FFF};

  // SRAM slave sizing and timing
  localparam int SRAM_DEPTH       = 8192;
  localparam int SRAM_ADDR_WIDTH  = $clog2(SRAM_DEPTH);
  localparam int SRAM_WAIT_STATES = 2;
  localparam int WAIT_CNT_WIDTH   = $clog2(SRAM_WAIT_STATES + 1);

  // NONSEQ and SEQ carry data, IDLE and BUSY do not
  function automatic logic htrans_active(htrans_type trans);
    return (trans == NONSEQ) || (trans == SEQ);
  endfunction

endpackage

`default_nettype wire
